/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module pulse_element_tb
	out=$$(./obj_dir/Vpulse_element_tb); echo "$$out"; \
		echo "$$out" | grep -qxF "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module pulse_element_tb

clean:
	rm -rf obj_dir

/* logic/am_modulator.sv */
`timescale 1ns/10ps
// envelope times carrier modulator
module am_modulator
	import elem_pkg::*;
(
	input logic elem,
	input logic reset,
	input logic in_valid,
	input iq_t env,
	input iq_t car,
	input logic signed [SAMPLE_W-1:0] amp,
	output logic out_valid,
	output iq_t out_sample
);

	logic signed [2*SAMPLE_W-1:0] pp_ii, pp_qq, pp_iq, pp_qi;  // partial products
	logic signed [2*SAMPLE_W:0] sum_i, sum_q;
	logic signed [2*SAMPLE_W-1:0] scl_i, scl_q;
	iq_t prod;
	logic [MOD_LAT-1:0] valid_sr;

	// stage 1, four partial products
	always_ff @(posedge elem) begin
		pp_ii <= env.i * car.i;
		pp_qq <= env.q * car.q;
		pp_iq <= env.i * car.q;
		pp_qi <= env.q * car.i;
	end

	assign sum_i = pp_ii - pp_qq;
	assign sum_q = pp_iq + pp_qi;

	// stage 2, complex sum back to Q1.15
	always_ff @(posedge elem) begin
		prod.i <= sum_i[SAMPLE_W+14:15];
		prod.q <= sum_q[SAMPLE_W+14:15];
	end

	assign scl_i = prod.i * amp;
	assign scl_q = prod.q * amp;

	// stage 3, amplitude scaling
	always_ff @(posedge elem) begin
		out_sample.i <= scl_i[SAMPLE_W+14:15];
		out_sample.q <= scl_q[SAMPLE_W+14:15];
	end

	always_ff @(posedge elem) begin
		if (reset)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[MOD_LAT-2:0], in_valid};
	end

	assign out_valid = valid_sr[MOD_LAT-1];

endmodule

/* logic/delay_line.sv */
`timescale 1ns/10ps
// fixed length delay line
module delay_line #(
	parameter type payload_t = logic,
	parameter int LEN = 1
) (
	input logic elem,
	input logic reset,
	input payload_t din,
	output payload_t dout
);

	payload_t stage [LEN];

	always_ff @(posedge elem) begin
		if (reset) begin
			for (int n = 0; n < LEN; n++)
				stage[n] <= '0;
		end else begin
			stage[0] <= din;
			for (int n = 1; n < LEN; n++)
				stage[n] <= stage[n-1];
		end
	end

	assign dout = stage[LEN-1];

	len_check: assert property (@(posedge elem) LEN >= 1)
		else $error("delay line needs at least one stage");

endmodule

/* logic/elem_fsm.sv */
`timescale 1ns/10ps
// pulse element controller
module elem_fsm
	import elem_pkg::*;
(
	input logic elem,
	input logic reset,
	input elem_cmd_t cmd,
	input logic cmd_stb,
	input logic last,
	output logic load,
	output logic run,
	output elem_cmd_t cmd_held,
	output logic busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_DRAIN
	} state_t;

	state_t state;
	logic [DRAIN_W-1:0] drain_cnt;
	logic accept;

	assign accept = (state == ST_IDLE) && cmd_stb;  // strobes while busy are dropped

	always_ff @(posedge elem) begin
		if (reset) begin
			state <= ST_IDLE;
			load <= 1'b0;
			drain_cnt <= '0;
		end else begin
			load <= accept;
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= ST_PLAY;
				end
				ST_PLAY: begin
					if (load && cmd_held.env_len == '0)
						state <= ST_IDLE;  // empty element, nothing to play
					else if (last) begin
						state <= ST_DRAIN;
						drain_cnt <= DRAIN_W'(DRAIN_LEN);
					end
				end
				ST_DRAIN: begin
					// wait for the rom and modulator pipeline to empty
					if (drain_cnt == DRAIN_W'(1))
						state <= ST_IDLE;
					else
						drain_cnt <= drain_cnt - 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge elem) begin
		if (accept)
			cmd_held <= cmd;
	end

	assign run = (state == ST_PLAY) && !load;  // timer loads during the load cycle
	assign busy = (state != ST_IDLE);

	load_from_idle: assert property (@(posedge elem) disable iff (reset)
		load |-> state == ST_PLAY && $past(state) == ST_IDLE)
		else $error("timer load issued outside idle");

endmodule

/* logic/elem_pkg.sv */
// pulse element types
package elem_pkg;

	localparam int TAB_ADDR_W = 8;
	localparam int TAB_DEPTH = 256;
	localparam int SAMPLE_W = 16;  // one I or Q component
	localparam int ACC_W = 32;
	localparam int SHIFT_W = 5;

	// pipeline depths
	localparam int ROM_LAT = 1;
	localparam int MOD_LAT = 3;
	localparam int ADC_DELAY = 6;  // loopback compensation
	localparam int MIX_LAT = 3;  // last product input to result strobe
	localparam int DRAIN_LEN = ROM_LAT + MOD_LAT;
	localparam int DRAIN_W = $clog2(DRAIN_LEN + 1);

	typedef struct packed {
		logic signed [SAMPLE_W-1:0] i;
		logic signed [SAMPLE_W-1:0] q;
	} iq_t;

	typedef struct packed {
		logic [TAB_ADDR_W-1:0] env_start;
		logic [TAB_ADDR_W-1:0] env_len;
		logic signed [SAMPLE_W-1:0] amp;  // Q1.15
		logic [TAB_ADDR_W-1:0] car_start;
	} elem_cmd_t;

	typedef struct packed {
		logic en;
		logic sel;  // 0 envelope, 1 carrier
		logic [TAB_ADDR_W-1:0] addr;
		iq_t data;
	} tab_wr_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] i;
		logic signed [ACC_W-1:0] q;
	} acc_t;

endpackage

/* logic/env_addr_timer.sv */
`timescale 1ns/10ps
// envelope and carrier address timer
module env_addr_timer
	import elem_pkg::*;
(
	input logic elem,
	input logic reset,
	input logic load,
	input logic run,
	input logic [TAB_ADDR_W-1:0] env_start,
	input logic [TAB_ADDR_W-1:0] car_start,
	input logic [TAB_ADDR_W-1:0] env_len,
	output logic [TAB_ADDR_W-1:0] env_addr,
	output logic [TAB_ADDR_W-1:0] car_addr,
	output logic last
);

	logic [TAB_ADDR_W-1:0] remain;  // samples still to present, current one included

	always_ff @(posedge elem) begin
		if (reset) begin
			env_addr <= '0;
			car_addr <= '0;
			remain <= '0;
		end else if (load) begin
			env_addr <= env_start;
			car_addr <= car_start;
			remain <= env_len;
		end else if (run) begin
			env_addr <= env_addr + 1'b1;  // wraps at table end
			car_addr <= car_addr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	assign last = run && (remain == TAB_ADDR_W'(1));

	// controller must drop run once the final sample went out
	remain_underflow: assert property (@(posedge elem) disable iff (reset)
		run |-> remain != '0)
		else $error("address timer running with no samples left");

endmodule

/* logic/mix_accumulator.sv */
`timescale 1ns/10ps
// ADC mixer and window accumulator
module mix_accumulator
	import elem_pkg::*;
(
	input logic elem,
	input logic reset,
	input iq_t sample,
	input logic sample_valid,
	input iq_t adc,
	input logic [SHIFT_W-1:0] shift,
	output logic acc_stb,
	output acc_t acc
);

	iq_t adc_d;
	acc_t prod;
	acc_t acc_sum;
	logic prod_valid;
	logic prod_valid_d;
	logic window_end;

	delay_line #(
		.payload_t(iq_t),
		.LEN(ADC_DELAY)
	) adc_delay_i (
		.elem,
		.reset,
		.din(adc),
		.dout(adc_d)
	);

	// complex product wraps to 32 bits
	always_ff @(posedge elem) begin
		prod.i <= adc_d.i * sample.i - adc_d.q * sample.q;
		prod.q <= adc_d.i * sample.q + adc_d.q * sample.i;
		if (prod_valid) begin
			// first product of the window restarts the sum
			acc_sum.i <= (prod_valid_d ? acc_sum.i : '0) + prod.i;
			acc_sum.q <= (prod_valid_d ? acc_sum.q : '0) + prod.q;
		end
	end

	assign window_end = prod_valid_d && !prod_valid;  // falling edge of delayed valid

	always_ff @(posedge elem) begin
		if (reset) begin
			prod_valid <= 1'b0;
			prod_valid_d <= 1'b0;
			acc_stb <= 1'b0;
			acc <= '0;
		end else begin
			prod_valid <= sample_valid;
			prod_valid_d <= prod_valid;
			acc_stb <= window_end;
			if (window_end) begin
				acc.i <= acc_sum.i >>> shift;
				acc.q <= acc_sum.q >>> shift;
			end
		end
	end

	stb_outside_window: assert property (@(posedge elem) disable iff (reset)
		acc_stb |-> !prod_valid)
		else $error("accumulator strobe inside a product window");

	stb_latency: assert property (@(posedge elem) disable iff (reset)
		acc_stb |-> $past(sample_valid, MIX_LAT) && !$past(sample_valid, MIX_LAT - 1))
		else $error("accumulator strobe not aligned to end of sample window");

endmodule

/* logic/pulse_element.sv */
`timescale 1ns/10ps
// pulse element top
module pulse_element
	import elem_pkg::*;
(
	input logic elem,
	input logic reset,
	input elem_cmd_t cmd,
	input logic cmd_stb,
	input tab_wr_t tab_wr,
	input iq_t adc,
	input logic [SHIFT_W-1:0] shift,
	output logic busy,
	output logic out_valid,
	output iq_t out_sample,
	output logic acc_stb,
	output acc_t acc
);

	elem_cmd_t cmd_held;
	logic load, run, last;
	logic [TAB_ADDR_W-1:0] env_addr, car_addr;
	logic env_wr_en, car_wr_en;
	iq_t env_data, car_data;
	logic mod_in_valid;

	assign env_wr_en = tab_wr.en && !tab_wr.sel;
	assign car_wr_en = tab_wr.en && tab_wr.sel;

	elem_fsm elem_fsm_i (
		.elem, .reset,
		.cmd, .cmd_stb,
		.last,
		.load, .run,
		.cmd_held,
		.busy
	);

	env_addr_timer env_addr_timer_i (
		.elem, .reset,
		.load, .run,
		.env_start(cmd_held.env_start),
		.car_start(cmd_held.car_start),
		.env_len(cmd_held.env_len),
		.env_addr, .car_addr,
		.last
	);

	wave_rom #(.word_t(iq_t)) env_rom_i (
		.elem,
		.wr_en(env_wr_en), .wr_addr(tab_wr.addr), .wr_data(tab_wr.data),
		.rd_addr(env_addr), .rd_data(env_data)
	);

	wave_rom #(.word_t(iq_t)) car_rom_i (
		.elem,
		.wr_en(car_wr_en), .wr_addr(tab_wr.addr), .wr_data(tab_wr.data),
		.rd_addr(car_addr), .rd_data(car_data)
	);

	// run level lined up with table read data
	delay_line #(.payload_t(logic), .LEN(ROM_LAT)) valid_delay_i (
		.elem, .reset,
		.din(run), .dout(mod_in_valid)
	);

	am_modulator am_modulator_i (
		.elem, .reset,
		.in_valid(mod_in_valid),
		.env(env_data), .car(car_data),
		.amp(cmd_held.amp),  // held for the whole element
		.out_valid, .out_sample
	);

	mix_accumulator mix_accumulator_i (
		.elem, .reset,
		.sample(out_sample), .sample_valid(out_valid),
		.adc, .shift,
		.acc_stb, .acc
	);

endmodule

/* logic/wave_rom.sv */
`timescale 1ns/10ps
// sample table memory
module wave_rom
	import elem_pkg::*;
#(
	parameter type word_t = iq_t
) (
	input logic elem,
	input logic wr_en,
	input logic [TAB_ADDR_W-1:0] wr_addr,
	input word_t wr_data,
	input logic [TAB_ADDR_W-1:0] rd_addr,
	output word_t rd_data
);

	word_t mem [TAB_DEPTH];

	// write port for table loading, read port is registered
	always_ff @(posedge elem) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];  // ROM_LAT of one
	end

endmodule

/* tb/pulse_element_tb.sv */
`timescale 1ns/10ps
// pulse element testbench
module pulse_element_tb
	import elem_pkg::*;
();

	localparam int N_CMDS = 10;

	logic elem, reset;
	elem_cmd_t cmd;
	logic cmd_stb;
	tab_wr_t tab_wr;
	iq_t adc;
	logic [SHIFT_W-1:0] shift;
	logic busy, out_valid, acc_stb;
	iq_t out_sample;
	acc_t acc;

	logic [31:0] lfsr_state = 32'h4acf;
	iq_t env_tab [TAB_DEPTH];  // mirrors of the two tables
	iq_t car_tab [TAB_DEPTH];
	elem_cmd_t cmds [N_CMDS];
	logic [SHIFT_W-1:0] shifts [N_CMDS];
	int limit_cycles;
	int windows;  // elements that should play
	int stb_seen = 0;
	int mismatches = 0;
	int failures = 0;

	// reference model state
	int cyc, busy_end, stb_cyc;
	int at_q [$];  // edge after which each expected sample shows
	iq_t val_q [$];
	iq_t adc_hist [$];
	acc_t win_sum;
	logic in_window;
	logic exp_busy, exp_valid, exp_stb;
	iq_t exp_sample;
	acc_t exp_acc;

	tb_clock clock_i (.elem, .reset);

	pulse_element pulse_element_i (
		.elem, .reset, .cmd, .cmd_stb, .tab_wr, .adc, .shift,
		.busy, .out_valid, .out_sample, .acc_stb, .acc
	);

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	// envelope times carrier, back to Q1.15, then scaled by amp
	function automatic iq_t mod_model(iq_t e, iq_t c, logic signed [SAMPLE_W-1:0] amp);
		longint pi, pq;
		iq_t p, r;
		pi = longint'(e.i) * longint'(c.i) - longint'(e.q) * longint'(c.q);
		pq = longint'(e.i) * longint'(c.q) + longint'(e.q) * longint'(c.i);
		p.i = 16'(pi >>> 15);
		p.q = 16'(pq >>> 15);
		r.i = 16'((longint'(p.i) * amp) >>> 15);
		r.q = 16'((longint'(p.q) * amp) >>> 15);
		return r;
	endfunction

	function automatic acc_t mix_model(iq_t a, iq_t s);
		acc_t r;
		r.i = 32'(longint'(a.i) * longint'(s.i) - longint'(a.q) * longint'(s.q));
		r.q = 32'(longint'(a.i) * longint'(s.q) + longint'(a.q) * longint'(s.i));
		return r;
	endfunction

	function automatic void report_mismatch(string name, logic [63:0] expected,
		logic [63:0] actual);
		mismatches++;
		$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endfunction

	function automatic void build_commands();
		elem_cmd_t c;
		limit_cycles = 2 * TAB_DEPTH + 20 + 200;
		windows = 0;
		for (int n = 0; n < N_CMDS; n++) begin
			c.env_start = 8'(rand_bits(8));
			c.car_start = 8'(rand_bits(8));
			c.env_len = 8'(1 + rand_bits(5));
			c.amp = 16'(rand_bits(16));
			if (n == 1) c.amp = 16'h8000;  // full negative scale
			if (n == 2) begin
				c.env_start = 8'hf4;  // envelope address wraps
				c.env_len = 8'd24;
			end
			if (n == 3) begin
				c.car_start = 8'hfa;  // carrier address wraps
				c.env_len = 8'd16;
			end
			if (n == 5) c.env_len = '0;
			if (n == N_CMDS - 1) c.env_len = 8'd60;
			cmds[n] = c;
			shifts[n] = (n % 3 == 0) ? 5'd0 : (n % 3 == 1) ? 5'd7 : 5'd31;
			limit_cycles += c.env_len + 24;
			if (c.env_len != 0) windows++;
		end
	endfunction

	task automatic next_cycle();
		@(posedge elem);
		#2;
		adc = iq_t'(rand_bits(32));  // fresh adc sample every cycle
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
	endtask

	// cycle accurate prediction of every output, from the timing and arithmetic rules
	always @(posedge elem) begin : model
		elem_cmd_t c;
		acc_t p;
		if (reset) begin
			cyc = 0;
			busy_end = -1;
			stb_cyc = -1;
			in_window = 1'b0;
			win_sum = '0;
			at_q.delete();
			val_q.delete();
			adc_hist.delete();
			for (int n = 0; n <= ADC_DELAY; n++)
				adc_hist.push_back('0);
			exp_busy <= 1'b0;
			exp_valid <= 1'b0;
			exp_sample <= '0;
			exp_stb <= 1'b0;
			exp_acc <= '0;
		end else begin
			cyc++;
			adc_hist.push_back(adc);
			void'(adc_hist.pop_front());  // front is now the adc seen ADC_DELAY edges ago
			if (cmd_stb && !exp_busy) begin
				c = cmd;
				busy_end = (c.env_len == 0) ? cyc : cyc + c.env_len + ROM_LAT + MOD_LAT;
				for (int k = 0; k < c.env_len; k++) begin
					at_q.push_back(cyc + ROM_LAT + MOD_LAT + 1 + k);
					val_q.push_back(mod_model(env_tab[8'(c.env_start + k)],
						car_tab[8'(c.car_start + k)], c.amp));
				end
			end
			exp_busy <= (cyc <= busy_end);
			if (at_q.size() > 0 && at_q[0] == cyc) begin
				exp_valid <= 1'b1;
				exp_sample <= val_q[0];
				void'(at_q.pop_front());
				void'(val_q.pop_front());
			end else
				exp_valid <= 1'b0;
			if (exp_valid) begin
				p = mix_model(adc_hist[0], exp_sample);
				win_sum.i = (in_window ? win_sum.i : '0) + p.i;
				win_sum.q = (in_window ? win_sum.q : '0) + p.q;
				in_window = 1'b1;
			end else if (in_window) begin
				in_window = 1'b0;
				stb_cyc = cyc + MIX_LAT - 2;
			end
			exp_stb <= (cyc == stb_cyc);
			if (cyc == stb_cyc) begin
				exp_acc.i <= win_sum.i >>> shift;
				exp_acc.q <= win_sum.q >>> shift;
			end
		end
	end

	busy_check: assert property (@(posedge elem) disable iff (reset) busy == exp_busy)
		else report_mismatch("busy", $sampled(exp_busy), $sampled(busy));
	valid_check: assert property (@(posedge elem) disable iff (reset) out_valid == exp_valid)
		else report_mismatch("out_valid", $sampled(exp_valid), $sampled(out_valid));
	sample_check: assert property (@(posedge elem) disable iff (reset)
		exp_valid |-> out_sample == exp_sample)
		else report_mismatch("out_sample", $sampled(exp_sample), $sampled(out_sample));
	stb_check: assert property (@(posedge elem) disable iff (reset) acc_stb == exp_stb)
		else report_mismatch("acc_stb", $sampled(exp_stb), $sampled(acc_stb));
	acc_check: assert property (@(posedge elem) disable iff (reset) acc == exp_acc)
		else report_mismatch("acc", $sampled(exp_acc), $sampled(acc));

	always @(posedge elem) begin
		if (!reset && acc_stb)
			stb_seen++;
	end

	initial begin : stimulus
		iq_t w;
		cmd = '0;
		cmd_stb = 1'b0;
		tab_wr = '0;
		adc = '0;
		shift = '0;
		build_commands();
		do @(posedge elem); while (reset);
		#2;
		for (int sel = 0; sel < 2; sel++) begin
			for (int a = 0; a < TAB_DEPTH; a++) begin
				w = iq_t'(rand_bits(32));
				tab_wr = '{en: 1'b1, sel: sel[0], addr: a[7:0], data: w};
				if (sel == 0)
					env_tab[a] = w;
				else
					car_tab[a] = w;
				next_cycle();
			end
		end
		tab_wr = '0;
		repeat (4) next_cycle();
		for (int n = 0; n < N_CMDS; n++) begin
			shift = shifts[n];
			cmd = cmds[n];
			cmd_stb = 1'b1;
			next_cycle();
			cmd_stb = 1'b0;
			if (n % 2 == 1 && cmds[n].env_len != 0) begin
				// a second strobe lands while busy and has to be dropped
				next_cycle();
				cmd = elem_cmd_t'({8'(rand_bits(8)), rand_bits(32)});
				cmd_stb = 1'b1;
				next_cycle();
				cmd_stb = 1'b0;
			end
			do next_cycle(); while (busy);
			repeat (6) next_cycle();  // lets the accumulator strobe out
		end
		repeat (10) next_cycle();
		if (val_q.size() != 0) begin
			failures++;
			$display("%0d expected output samples never appeared", val_q.size());
		end
		if (stb_seen != windows) begin
			failures++;
			$display("saw %0d accumulator strobes for %0d played elements", stb_seen, windows);
		end
		print_counts();
		if (mismatches + failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin : watchdog
		#1;
		#(longint'(limit_cycles) * 40);
		failures++;
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		print_counts();
		$display("Some tests failed");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/10ps
// clock and reset source
module tb_clock #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic elem,
	output logic reset
);

	initial begin
		elem = 1'b0;
		forever #(PERIOD / 2) elem = ~elem;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge elem);
		#2 reset = 1'b0;  // released just after an edge, like the other inputs
	end

endmodule

/* vlog.f */
logic/elem_pkg.sv
logic/delay_line.sv
logic/wave_rom.sv
logic/env_addr_timer.sv
logic/elem_fsm.sv
logic/am_modulator.sv
logic/mix_accumulator.sv
logic/pulse_element.sv
tb/tb_clock.sv
tb/pulse_element_tb.sv
